/* verilog/chdr_dma_macros.svh */
/*
  Build-time constants of the CHDR receive-to-host pad path.
  Include wherever a width or depth is needed; the guard keeps
  repeated includes harmless.
*/

`ifndef CHDR_DMA_MACROS_SVH
`define CHDR_DMA_MACROS_SVH

// Width of one CHDR line in bits
`define CHDR_W 64

// Elastic FIFO depth in lines, power of two only
`define CHDR_FIFO_DEPTH 8

// Width of each software statistics counter
`define CHDR_CNT_W 16

`endif

/* verilog/chdr_dma_pkg.sv */
/*
  Shared types of the CHDR pad path: the stream beat, the event
  pulses from the padder and the padder FSM states.
  Modules import it inside their bodies.
*/

`default_nettype none
`include "chdr_dma_macros.svh"

package chdr_dma_pkg;

  // One stream line with its end-of-packet flag
  typedef struct packed {
    logic [`CHDR_W-1:0] data;
    logic               last;
  } chdr_beat_t;

  // Single-cycle pulses toward the statistics block
  typedef struct packed {
    logic pkt_done;
    logic padded;
    logic truncated;
  } pad_event_t;

  // Padder FSM
  typedef enum logic [1:0] {
    ST_HEADER = 2'd0,
    ST_BODY   = 2'd1,
    ST_PAD    = 2'd2,
    ST_DROP   = 2'd3
  } pad_state_e;

endpackage

`default_nettype wire

/* verilog/chdr_axis_fifo.sv */
/*
  Small synchronous AXI-Stream FIFO in front of the padder.
  Absorbs input while the padder inserts pad lines or the DMA stalls.
  One cycle from write to visible output.
*/

`default_nettype none
`include "chdr_dma_macros.svh"

module chdr_axis_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  chdr_dma_pkg::chdr_beat_t s_beat,
  input  logic                     s_valid,
  output logic                     s_ready,
  output chdr_dma_pkg::chdr_beat_t m_beat,
  output logic                     m_valid,
  input  logic                     m_ready
);

  import chdr_dma_pkg::*;

  localparam int unsigned DEPTH = `CHDR_FIFO_DEPTH;
  localparam int unsigned AW    = $clog2(DEPTH);

  // Storage, payload only
  chdr_beat_t mem [DEPTH];

  // Pointers with one extra wrap bit
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  // Same index, different lap means full
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // A full FIFO still takes a beat when one leaves in the same cycle
  assign s_ready = !full || m_ready;
  assign m_valid = !empty;

  assign wr_en = s_valid && s_ready;
  assign rd_en = m_valid && m_ready;

  // Head of queue straight from the array
  assign m_beat = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= s_beat;
    end
  end

  // Write pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Read pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/chdr_pad_packet.sv */
/*
  Forces every CHDR packet to exactly len lines for the DMA engine.
  Short packets get zero lines appended, long ones are cut and the
  tail dropped. A len of 1 or less holds both sides still.
  Registered event pulses feed the statistics block.
*/

`default_nettype none

module chdr_pad_packet (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [15:0]              len,
  input  chdr_dma_pkg::chdr_beat_t s_beat,
  input  logic                     s_valid,
  output logic                     s_ready,
  output chdr_dma_pkg::chdr_beat_t m_beat,
  output logic                     m_valid,
  input  logic                     m_ready,
  output chdr_dma_pkg::pad_event_t event_o
);

  import chdr_dma_pkg::*;

  pad_state_e  state;
  logic [15:0] lines_left;

  logic len_ok;
  logic in_xfer;
  logic out_xfer;
  logic final_line;

  // Stall mode below two lines
  assign len_ok = (len > 16'd1);

  assign in_xfer    = s_valid && s_ready;
  assign out_xfer   = m_valid && m_ready;
  assign final_line = (lines_left == 16'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_HEADER;
      lines_left <= '0;
      event_o    <= '0;
    end else begin
      // Pulses last one cycle
      event_o <= '0;
      if (!len_ok) begin
        state <= ST_HEADER;
      end else begin
        case (state)
          ST_HEADER: begin
            // Header line counts as the first of len
            lines_left <= len - 16'd1;
            if (out_xfer) begin
              if (s_beat.last) begin
                // One-line packet, rest is padding
                state <= ST_PAD;
              end else begin
                state <= ST_BODY;
              end
            end
          end
          ST_BODY: begin
            if (out_xfer) begin
              lines_left <= lines_left - 16'd1;
              if (final_line) begin
                event_o.pkt_done <= 1'b1;
                if (s_beat.last) begin
                  // Exact fit
                  state <= ST_HEADER;
                end else begin
                  // Length reached, input goes on
                  event_o.truncated <= 1'b1;
                  state             <= ST_DROP;
                end
              end else if (s_beat.last) begin
                // Input ended early
                state <= ST_PAD;
              end
            end
          end
          ST_PAD: begin
            if (out_xfer) begin
              lines_left <= lines_left - 16'd1;
              if (final_line) begin
                event_o.pkt_done <= 1'b1;
                event_o.padded   <= 1'b1;
                state            <= ST_HEADER;
              end
            end
          end
          ST_DROP: begin
            // Discard until the input tail ends
            if (in_xfer && s_beat.last) begin
              state <= ST_HEADER;
            end
          end
          default: begin
            state <= ST_HEADER;
          end
        endcase
      end
    end
  end

  // Stream steering per state
  always_comb begin
    m_beat.data = s_beat.data;
    m_beat.last = 1'b0;
    s_ready     = 1'b0;
    m_valid     = 1'b0;
    case (state)
      ST_HEADER: begin
        if (len_ok) begin
          s_ready = m_ready;
          m_valid = s_valid;
        end
      end
      ST_BODY: begin
        s_ready     = m_ready;
        m_valid     = s_valid;
        m_beat.last = final_line;
      end
      ST_PAD: begin
        // Zero lines, input held off
        m_valid     = 1'b1;
        m_beat.data = '0;
        m_beat.last = final_line;
      end
      ST_DROP: begin
        s_ready = 1'b1;
      end
      default: begin
        s_ready = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/chdr_pad_stats.sv */
/*
  Packet statistics for software: completed, padded and truncated
  packets, counted from the padder event pulses. Counters wrap.
*/

`default_nettype none
`include "chdr_dma_macros.svh"

module chdr_pad_stats (
  input  logic                     clk,
  input  logic                     rst_n,
  input  chdr_dma_pkg::pad_event_t event_i,
  output logic [`CHDR_CNT_W-1:0]   pkt_count,
  output logic [`CHDR_CNT_W-1:0]   pad_count,
  output logic [`CHDR_CNT_W-1:0]   trunc_count
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_count   <= '0;
      pad_count   <= '0;
      trunc_count <= '0;
    end else begin
      // Every output packet of len lines
      if (event_i.pkt_done) begin
        pkt_count <= pkt_count + 1'b1;
      end
      // Packets that needed zero lines
      if (event_i.padded) begin
        pad_count <= pad_count + 1'b1;
      end
      // Input packets that lost their tail
      if (event_i.truncated) begin
        trunc_count <= trunc_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/chdr_dma_pad_top.sv */
/*
  Receive-to-host pad path: elastic FIFO, then the padder, with
  statistics on the side. The output feeds the DMA engine.
*/

`default_nettype none
`include "chdr_dma_macros.svh"

module chdr_dma_pad_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [15:0]              len,
  input  chdr_dma_pkg::chdr_beat_t s_beat,
  input  logic                     s_valid,
  output logic                     s_ready,
  output chdr_dma_pkg::chdr_beat_t m_beat,
  output logic                     m_valid,
  input  logic                     m_ready,
  output logic [`CHDR_CNT_W-1:0]   pkt_count,
  output logic [`CHDR_CNT_W-1:0]   pad_count,
  output logic [`CHDR_CNT_W-1:0]   trunc_count
);

  import chdr_dma_pkg::*;

  // FIFO to padder stream
  chdr_beat_t f_beat;
  logic       f_valid;
  logic       f_ready;

  pad_event_t pad_event;

  chdr_axis_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (f_beat),
    .m_valid (f_valid),
    .m_ready (f_ready)
  );

  chdr_pad_packet u_pad (
    .clk     (clk),
    .rst_n   (rst_n),
    .len     (len),
    .s_beat  (f_beat),
    .s_valid (f_valid),
    .s_ready (f_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .event_o (pad_event)
  );

  chdr_pad_stats u_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .event_i     (pad_event),
    .pkt_count   (pkt_count),
    .pad_count   (pad_count),
    .trunc_count (trunc_count)
  );

endmodule

`default_nettype wire

/* test/tb_chdr_dma_pad.sv */
/*
  Self-checking testbench for the CHDR DMA pad path.
  LFSR-driven packets go in, a queue model holds the expected padded or
  truncated lines and assertions check every output transfer.
*/

`default_nettype none
`include "chdr_dma_macros.svh"

module tb_chdr_dma_pad;
  timeunit 1ns;
  timeprecision 1ps;

  import chdr_dma_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_LINES  = 12;
  // 39 packets of at most MAX_LINES lines in or out
  localparam int TEST_BEATS = 39 * MAX_LINES;

  logic                  clk;
  logic                  rst_n;
  logic [15:0]           len;
  chdr_beat_t            s_beat;
  logic                  s_valid;
  logic                  s_ready;
  chdr_beat_t            m_beat;
  logic                  m_valid;
  logic                  m_ready;
  logic [`CHDR_CNT_W-1:0] pkt_count;
  logic [`CHDR_CNT_W-1:0] pad_count;
  logic [`CHDR_CNT_W-1:0] trunc_count;

  logic [31:0] lfsr;
  chdr_beat_t  exp_q[$];
  chdr_beat_t  exp_beat;
  logic        s_fire;
  logic        heavy;
  int          errors;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  int          model_pkts;
  int          model_pads;
  int          model_truncs;

  chdr_dma_pad_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .len         (len),
    .s_beat      (s_beat),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .m_beat      (m_beat),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .pkt_count   (pkt_count),
    .pad_count   (pad_count),
    .trunc_count (trunc_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Budget of 40 cycles per test beat
  initial begin
    #(TEST_BEATS * 40 * CLK_PERIOD);
    $display("Timeout: the output did not deliver all expected lines in time");
    $display("*** FAILED ***");
    $finish;
  end

  // Galois step with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Sample the input handshake at the edge, then drive
  task automatic next_cycle();
    @(posedge clk);
    s_fire = s_valid && s_ready;
    #1;
    m_ready = heavy ? (take_bits(1) != 0) : (take_bits(2) != 0);
  endtask

  // Queue the expected lines, then push the packet through the handshake
  task automatic send_packet(input int in_len, input int out_len);
    chdr_beat_t pkt[$];
    chdr_beat_t line;
    int         i;
    for (i = 0; i < in_len; i++) begin
      line.data = {take_bits(32), take_bits(32)};
      line.last = (i == in_len - 1);
      pkt.push_back(line);
    end
    // Input lines first, zero lines to out_len, last only on the final one
    for (i = 0; i < out_len; i++) begin
      line.data = (i < in_len) ? pkt[i].data : '0;
      line.last = (i == out_len - 1);
      exp_q.push_back(line);
    end
    model_pkts++;
    if (in_len < out_len) model_pads++;
    if (in_len > out_len) model_truncs++;
    for (i = 0; i < in_len; i++) begin
      while (take_bits(heavy ? 1 : 2) == 0) begin
        s_valid = 1'b0;
        next_cycle();
      end
      s_beat  = pkt[i];
      s_valid = 1'b1;
      do next_cycle(); while (!s_fire);
    end
    s_valid = 1'b0;
  endtask

  task automatic drain_output();
    s_valid = 1'b0;
    while (exp_q.size() != 0) next_cycle();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name,
             (errors == err_mark) ? "ok" : "failing", errors - err_mark);
    err_mark = errors;
  endtask

  // Every output transfer against the head of the model queue
  always @(posedge clk) begin
    if (rst_n && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output transfer seen while no line was expected");
        errors++;
      end else begin
        exp_beat = exp_q.pop_front();
        assert (m_beat.data == exp_beat.data) else begin
          $display("Fail m_beat.data: expected %h, got %h", exp_beat.data, m_beat.data);
          errors++;
        end
        assert (m_beat.last == exp_beat.last) else begin
          $display("Fail m_beat.last: expected %h, got %h", exp_beat.last, m_beat.last);
          errors++;
        end
      end
    end
  end

  // Held beat stays put until taken
  assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
  else begin
    $display("Output beat changed or vanished while waiting for m_ready");
    errors++;
  end

  // Stall mode keeps the output quiet
  assert property (@(posedge clk) disable iff (!rst_n) (len <= 16'd1) |-> !m_valid)
  else begin
    $display("Output went valid while len was 1 or less");
    errors++;
  end

  initial begin
    lfsr         = 32'heb98cb87;
    rst_n        = 1'b0;
    len          = 16'd6;
    s_beat       = '0;
    s_valid      = 1'b0;
    m_ready      = 1'b0;
    heavy        = 1'b0;
    s_fire       = 1'b0;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_pkts   = 0;
    model_pads   = 0;
    model_truncs = 0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    // Short packets with a one-line packet first
    len = 16'd6;
    send_packet(1, 6);
    repeat (5) send_packet(1 + take_bits(3) % 5, 6);
    drain_output();
    end_test("padding");

    len = 16'd5;
    repeat (4) send_packet(5, 5);
    drain_output();
    end_test("exact length");

    // Long packets followed by a short one that must start clean
    len = 16'd4;
    repeat (5) send_packet(5 + take_bits(3), 4);
    send_packet(2, 4);
    drain_output();
    end_test("truncation");

    // Half the cycles stalled on both sides
    // Closing packet fits in len so no drop is left pending
    heavy = 1'b1;
    len   = 16'd2 + 16'(take_bits(3));
    repeat (19) send_packet(1 + take_bits(4) % 12, int'(len));
    send_packet(1 + take_bits(1), int'(len));
    drain_output();
    heavy = 1'b0;
    end_test("back-pressure");

    // Eight beats fill the FIFO while the padder is held
    len = 16'd1;
    send_packet(5, 4);
    send_packet(3, 4);
    assert (!s_ready) else begin
      $display("s_ready stayed high although the FIFO is full in stall mode");
      errors++;
    end
    repeat (4) next_cycle();
    assert (!s_ready) else begin
      $display("s_ready rose while the padder was still stalled");
      errors++;
    end
    len = 16'd4;
    send_packet(2, 4);
    drain_output();
    end_test("stall mode");

    // Pulse comes one cycle late and the count on the following edge
    next_cycle();
    next_cycle();
    assert (pkt_count == model_pkts[`CHDR_CNT_W-1:0]) else begin
      $display("Fail pkt_count: expected %h, got %h", model_pkts[`CHDR_CNT_W-1:0], pkt_count);
      errors++;
    end
    assert (pad_count == model_pads[`CHDR_CNT_W-1:0]) else begin
      $display("Fail pad_count: expected %h, got %h", model_pads[`CHDR_CNT_W-1:0], pad_count);
      errors++;
    end
    assert (trunc_count == model_truncs[`CHDR_CNT_W-1:0]) else begin
      $display("Fail trunc_count: expected %h, got %h",
               model_truncs[`CHDR_CNT_W-1:0], trunc_count);
      errors++;
    end
    end_test("statistics");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/chdr_dma_pkg.sv
verilog/chdr_axis_fifo.sv
verilog/chdr_pad_packet.sv
verilog/chdr_pad_stats.sv
verilog/chdr_dma_pad_top.sv
test/tb_chdr_dma_pad.sv

/* Bender.yml */
package:
  name: chdr_dma_pad

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/chdr_dma_pkg.sv
      - verilog/chdr_axis_fifo.sv
      - verilog/chdr_pad_packet.sv
      - verilog/chdr_pad_stats.sv
      - verilog/chdr_dma_pad_top.sv
  - target: test
    files:
      - test/tb_chdr_dma_pad.sv
